//--- hw/simd_fp_pkg.sv
package simd_fp_pkg;

  // --------------------------------------------------
  // Data path geometry
  // --------------------------------------------------
  localparam int unsigned FLEN       = 64;
  localparam int unsigned LANE_WIDTH = 32;
  // One lane per FP16 element
  localparam int unsigned NUM_LANES  = 4;

  // --------------------------------------------------
  // Formats and operations
  // --------------------------------------------------
  typedef enum logic {
    FP32 = 1'b0,
    FP16 = 1'b1
  } fp_format_e;

  typedef enum logic {
    SGNJ   = 1'b0,
    MINMAX = 1'b1
  } operation_e;

  // Variant select for the non-computational ops
  // MINMAX uses RNE as min and RTZ as max
  // SGNJ uses RNE as sgnj, RTZ as sgnjn and RDN as sgnjx
  typedef enum logic [2:0] {
    RNE = 3'b000,
    RTZ = 3'b001,
    RDN = 3'b010
  } roundmode_e;

  // --------------------------------------------------
  // Status word
  // --------------------------------------------------
  localparam int unsigned STATUS_WIDTH = 5;

  localparam int unsigned STATUS_NV = 4;
  localparam int unsigned STATUS_DZ = 3;
  localparam int unsigned STATUS_OF = 2;
  localparam int unsigned STATUS_UF = 1;
  localparam int unsigned STATUS_NX = 0;

  // Canonical quiet NaNs
  localparam logic [31:0] CANON_NAN_FP32 = 32'h7FC0_0000;
  localparam logic [15:0] CANON_NAN_FP16 = 16'h7E00;

  // One operand word seen as packed elements of either format
  typedef union packed {
    logic [1:0][31:0] fp32;
    logic [3:0][15:0] fp16;
  } operand_u;

endpackage

//--- hw/simd_operand_unpack.sv
`timescale 1ns/10ps

module simd_operand_unpack (
  input  logic [simd_fp_pkg::FLEN-1:0]                                   op_a_i,
  input  logic [simd_fp_pkg::FLEN-1:0]                                   op_b_i,
  input  simd_fp_pkg::fp_format_e                                        fmt_i,
  input  logic                                                           vectorial_op_i,
  input  logic                                                           in_valid_i,
  output logic [simd_fp_pkg::NUM_LANES-1:0][simd_fp_pkg::LANE_WIDTH-1:0] lane_a_o,
  output logic [simd_fp_pkg::NUM_LANES-1:0][simd_fp_pkg::LANE_WIDTH-1:0] lane_b_o,
  output logic [simd_fp_pkg::NUM_LANES-1:0]                              lane_valid_o
);

  localparam int unsigned NumFp32 = simd_fp_pkg::FLEN / simd_fp_pkg::LANE_WIDTH;

  simd_fp_pkg::operand_u op_a_u;
  simd_fp_pkg::operand_u op_b_u;

  assign op_a_u = op_a_i;
  assign op_b_u = op_b_i;

  // Split one operand into lanes, FP16 elements sit in the low half of a lane
  function automatic logic [simd_fp_pkg::NUM_LANES-1:0][simd_fp_pkg::LANE_WIDTH-1:0]
      split_operand(input simd_fp_pkg::operand_u op, input simd_fp_pkg::fp_format_e fmt,
                    input logic vec);
    logic [simd_fp_pkg::NUM_LANES-1:0][simd_fp_pkg::LANE_WIDTH-1:0] lanes;
    lanes = '1;
    if (fmt == simd_fp_pkg::FP32) begin
      for (int i = 0; i < NumFp32; i++) begin
        lanes[i] = op.fp32[i];
      end
      // Scalar element must be NaN-boxed
      if (!vec && (op.fp32[NumFp32-1:1] != '1)) begin
        lanes[0] = simd_fp_pkg::CANON_NAN_FP32;
      end
    end else begin
      for (int i = 0; i < simd_fp_pkg::NUM_LANES; i++) begin
        lanes[i][15:0] = op.fp16[i];
      end
      if (!vec && (op.fp16[simd_fp_pkg::NUM_LANES-1:1] != '1)) begin
        lanes[0][15:0] = simd_fp_pkg::CANON_NAN_FP16;
      end
    end
    return lanes;
  endfunction

  assign lane_a_o = split_operand(op_a_u, fmt_i, vectorial_op_i);
  assign lane_b_o = split_operand(op_b_u, fmt_i, vectorial_op_i);

  // --------------------------------------------------
  // Lane valids
  // --------------------------------------------------
  always_comb begin
    lane_valid_o    = '0;
    lane_valid_o[0] = in_valid_i;
    for (int i = 1; i < simd_fp_pkg::NUM_LANES; i++) begin
      // Upper lanes only in vector mode and only if the format has an element there
      lane_valid_o[i] = in_valid_i & vectorial_op_i &
                        ((fmt_i == simd_fp_pkg::FP16) || (i < NumFp32));
    end
  end

endmodule

//--- hw/noncomp_lane.sv
`timescale 1ns/10ps

module noncomp_lane #(
  parameter int unsigned NumPipeRegs = 2
) (
  input  logic                               clk_i,
  input  logic                               rst_n_i,
  input  logic [simd_fp_pkg::LANE_WIDTH-1:0] a_i,
  input  logic [simd_fp_pkg::LANE_WIDTH-1:0] b_i,
  input  simd_fp_pkg::operation_e            op_i,
  input  simd_fp_pkg::roundmode_e            rnd_mode_i,
  input  simd_fp_pkg::fp_format_e            fmt_i,
  output logic [simd_fp_pkg::LANE_WIDTH-1:0] result_o,
  output logic                               nv_o
);

  logic        is_fp16;
  logic        sign_a, sign_b, new_sign;
  logic [30:0] mag_a, mag_b;
  logic        a_nan, b_nan, a_snan, b_snan;
  logic        a_zero, b_zero;
  logic        a_lt_b, pick_a;
  logic [simd_fp_pkg::LANE_WIDTH-1:0] canon_nan, sgnj_res, res_d;
  logic        nv_d;

  // --------------------------------------------------
  // Operand classification
  // --------------------------------------------------
  assign is_fp16 = (fmt_i == simd_fp_pkg::FP16);

  assign sign_a = is_fp16 ? a_i[15] : a_i[31];
  assign sign_b = is_fp16 ? b_i[15] : b_i[31];
  assign mag_a  = is_fp16 ? {16'b0, a_i[14:0]} : a_i[30:0];
  assign mag_b  = is_fp16 ? {16'b0, b_i[14:0]} : b_i[30:0];

  // Exponent all ones with a nonzero mantissa
  assign a_nan  = is_fp16 ? (&a_i[14:10] && |a_i[9:0]) : (&a_i[30:23] && |a_i[22:0]);
  assign b_nan  = is_fp16 ? (&b_i[14:10] && |b_i[9:0]) : (&b_i[30:23] && |b_i[22:0]);
  assign a_snan = a_nan & ~(is_fp16 ? a_i[9] : a_i[22]);
  assign b_snan = b_nan & ~(is_fp16 ? b_i[9] : b_i[22]);
  assign a_zero = (mag_a == '0);
  assign b_zero = (mag_b == '0);

  // Sign-magnitude order, -0 below +0
  always_comb begin
    if (a_zero && b_zero) begin
      a_lt_b = sign_a & ~sign_b;
    end else if (sign_a != sign_b) begin
      a_lt_b = sign_a;
    end else if (sign_a) begin
      a_lt_b = (mag_a > mag_b);
    end else begin
      a_lt_b = (mag_a < mag_b);
    end
  end

  assign pick_a    = (rnd_mode_i == simd_fp_pkg::RTZ) ? ~a_lt_b : a_lt_b;
  assign canon_nan = is_fp16 ? {16'hFFFF, simd_fp_pkg::CANON_NAN_FP16}
                             : simd_fp_pkg::CANON_NAN_FP32;

  // Sign injection variants
  always_comb begin
    case (rnd_mode_i)
      simd_fp_pkg::RTZ: new_sign = ~sign_b;
      simd_fp_pkg::RDN: new_sign = sign_a ^ sign_b;
      default:          new_sign = sign_b;
    endcase
  end

  assign sgnj_res = is_fp16 ? {16'hFFFF, new_sign, a_i[14:0]} : {new_sign, a_i[30:0]};

  always_comb begin
    nv_d = 1'b0;
    if (op_i == simd_fp_pkg::MINMAX) begin
      nv_d = a_snan | b_snan;
      if (a_nan && b_nan)  res_d = canon_nan;
      else if (a_nan)      res_d = b_i;
      else if (b_nan)      res_d = a_i;
      else                 res_d = pick_a ? a_i : b_i;
    end else begin
      res_d = sgnj_res;
    end
  end

  // --------------------------------------------------
  // Result pipeline
  // --------------------------------------------------
  logic [simd_fp_pkg::LANE_WIDTH-1:0] res_q [0:NumPipeRegs];
  logic                               nv_q  [0:NumPipeRegs];

  assign res_q[0] = res_d;
  assign nv_q[0]  = nv_d;

  for (genvar i = 0; i < NumPipeRegs; i++) begin : gen_stage
    always_ff @(posedge clk_i) begin
      res_q[i+1] <= res_q[i];
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
        nv_q[i+1] <= 1'b0;
      end else begin
        nv_q[i+1] <= nv_q[i];
      end
    end
  end

  assign result_o = res_q[NumPipeRegs];
  assign nv_o     = nv_q[NumPipeRegs];

endmodule

//--- hw/slice_meta_pipe.sv
`timescale 1ns/10ps

module slice_meta_pipe #(
  parameter int unsigned NumPipeRegs = 2,
  parameter int unsigned TagWidth    = 8
) (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  input  logic                              valid_i,
  input  logic [simd_fp_pkg::NUM_LANES-1:0] lane_valid_i,
  input  simd_fp_pkg::fp_format_e           fmt_i,
  input  logic                              vectorial_i,
  input  logic [simd_fp_pkg::NUM_LANES-1:0] mask_i,
  input  logic [TagWidth-1:0]               tag_i,
  output logic                              valid_o,
  output logic [simd_fp_pkg::NUM_LANES-1:0] lane_valid_o,
  output simd_fp_pkg::fp_format_e           fmt_o,
  output logic                              vectorial_o,
  output logic [simd_fp_pkg::NUM_LANES-1:0] mask_o,
  output logic [TagWidth-1:0]               tag_o,
  output logic                              busy_o
);

  // Index i holds the field after i register stages
  logic                              valid_q      [0:NumPipeRegs];
  logic [simd_fp_pkg::NUM_LANES-1:0] lane_valid_q [0:NumPipeRegs];
  simd_fp_pkg::fp_format_e           fmt_q        [0:NumPipeRegs];
  logic                              vec_q        [0:NumPipeRegs];
  logic [simd_fp_pkg::NUM_LANES-1:0] mask_q       [0:NumPipeRegs];
  logic [TagWidth-1:0]               tag_q        [0:NumPipeRegs];

  assign valid_q[0]      = valid_i;
  assign lane_valid_q[0] = lane_valid_i;
  assign fmt_q[0]        = fmt_i;
  assign vec_q[0]        = vectorial_i;
  assign mask_q[0]       = mask_i;
  assign tag_q[0]        = tag_i;

  for (genvar i = 0; i < NumPipeRegs; i++) begin : gen_stage
    always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
        valid_q[i+1]      <= 1'b0;
        lane_valid_q[i+1] <= '0;
      end else begin
        valid_q[i+1]      <= valid_q[i];
        lane_valid_q[i+1] <= lane_valid_q[i];
      end
    end

    always_ff @(posedge clk_i) begin
      fmt_q[i+1]  <= fmt_q[i];
      vec_q[i+1]  <= vec_q[i];
      mask_q[i+1] <= mask_q[i];
      tag_q[i+1]  <= tag_q[i];
    end
  end

  // Any occupied stage, the output stage included
  always_comb begin
    busy_o = valid_q[NumPipeRegs];
    for (int i = 1; i < NumPipeRegs; i++) begin
      busy_o |= valid_q[i];
    end
  end

  assign valid_o      = valid_q[NumPipeRegs];
  assign lane_valid_o = lane_valid_q[NumPipeRegs];
  assign fmt_o        = fmt_q[NumPipeRegs];
  assign vectorial_o  = vec_q[NumPipeRegs];
  assign mask_o       = mask_q[NumPipeRegs];
  assign tag_o        = tag_q[NumPipeRegs];

endmodule

//--- hw/simd_result_pack.sv
`timescale 1ns/10ps

module simd_result_pack (
  input  logic [simd_fp_pkg::NUM_LANES-1:0][simd_fp_pkg::LANE_WIDTH-1:0] lane_result_i,
  input  logic [simd_fp_pkg::NUM_LANES-1:0]                              lane_nv_i,
  input  logic [simd_fp_pkg::NUM_LANES-1:0]                              lane_valid_i,
  input  logic [simd_fp_pkg::NUM_LANES-1:0]                              mask_i,
  input  simd_fp_pkg::fp_format_e                                        fmt_i,
  input  logic                                                           vectorial_i,
  output logic [simd_fp_pkg::FLEN-1:0]                                   result_o,
  output logic [simd_fp_pkg::STATUS_WIDTH-1:0]                           status_o
);

  localparam int unsigned NumFp32 = simd_fp_pkg::FLEN / simd_fp_pkg::LANE_WIDTH;

  simd_fp_pkg::operand_u res_u;
  logic                  nv_any;

  // --------------------------------------------------
  // Result assembly
  // --------------------------------------------------
  // Unused element slots stay all ones, which NaN-boxes scalar results
  always_comb begin
    res_u = '1;
    if (fmt_i == simd_fp_pkg::FP32) begin
      for (int i = 0; i < NumFp32; i++) begin
        if ((i == 0) || vectorial_i) begin
          res_u.fp32[i] = lane_result_i[i];
        end
      end
    end else begin
      for (int i = 0; i < simd_fp_pkg::NUM_LANES; i++) begin
        if ((i == 0) || vectorial_i) begin
          res_u.fp16[i] = lane_result_i[i][15:0];
        end
      end
    end
  end

  assign result_o = res_u;

  // --------------------------------------------------
  // Status collapse
  // --------------------------------------------------
  // Only active and unmasked lanes may raise invalid
  assign nv_any = |(lane_nv_i & lane_valid_i & mask_i);

  always_comb begin
    status_o[simd_fp_pkg::STATUS_NV] = nv_any;
    // No rounding or arithmetic here, so the other flags never fire
    status_o[simd_fp_pkg::STATUS_DZ] = 1'b0;
    status_o[simd_fp_pkg::STATUS_OF] = 1'b0;
    status_o[simd_fp_pkg::STATUS_UF] = 1'b0;
    status_o[simd_fp_pkg::STATUS_NX] = 1'b0;
  end

endmodule

//--- hw/noncomp_multifmt_slice.sv
`timescale 1ns/10ps

module noncomp_multifmt_slice #(
  parameter int unsigned NumPipeRegs = 2,
  parameter int unsigned TagWidth    = 8
) (
  input  logic                                 clk_i,
  input  logic                                 rst_n_i,
  input  logic                                 in_valid_i,
  input  logic [simd_fp_pkg::FLEN-1:0]         op_a_i,
  input  logic [simd_fp_pkg::FLEN-1:0]         op_b_i,
  input  simd_fp_pkg::operation_e              op_i,
  input  simd_fp_pkg::roundmode_e              rnd_mode_i,
  input  simd_fp_pkg::fp_format_e              fmt_i,
  input  logic                                 vectorial_op_i,
  input  logic [simd_fp_pkg::NUM_LANES-1:0]    simd_mask_i,
  input  logic [TagWidth-1:0]                  tag_i,
  output logic [simd_fp_pkg::FLEN-1:0]         result_o,
  output logic [simd_fp_pkg::STATUS_WIDTH-1:0] status_o,
  output logic [TagWidth-1:0]                  tag_o,
  output logic                                 out_valid_o,
  output logic                                 busy_o
);

  logic [simd_fp_pkg::NUM_LANES-1:0][simd_fp_pkg::LANE_WIDTH-1:0] lane_a, lane_b, lane_result;
  logic [simd_fp_pkg::NUM_LANES-1:0] lane_valid, lane_nv;

  // Sideband after the pipeline
  logic [simd_fp_pkg::NUM_LANES-1:0] lane_valid_q, mask_q;
  simd_fp_pkg::fp_format_e           fmt_q;
  logic                              vectorial_q;

  // --------------------------------------------------
  // Input side
  // --------------------------------------------------
  simd_operand_unpack i_unpack (
    .op_a_i         (op_a_i),
    .op_b_i         (op_b_i),
    .fmt_i          (fmt_i),
    .vectorial_op_i (vectorial_op_i),
    .in_valid_i     (in_valid_i),
    .lane_a_o       (lane_a),
    .lane_b_o       (lane_b),
    .lane_valid_o   (lane_valid)
  );

  // --------------------------------------------------
  // Lanes and sideband pipe
  // --------------------------------------------------
  for (genvar lane = 0; lane < simd_fp_pkg::NUM_LANES; lane++) begin : gen_lanes
    noncomp_lane #(.NumPipeRegs(NumPipeRegs)) i_lane (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .a_i        (lane_a[lane]),
      .b_i        (lane_b[lane]),
      .op_i       (op_i),
      .rnd_mode_i (rnd_mode_i),
      .fmt_i      (fmt_i),
      .result_o   (lane_result[lane]),
      .nv_o       (lane_nv[lane])
    );
  end

  slice_meta_pipe #(.NumPipeRegs(NumPipeRegs), .TagWidth(TagWidth)) i_meta (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .valid_i      (in_valid_i),
    .lane_valid_i (lane_valid),
    .fmt_i        (fmt_i),
    .vectorial_i  (vectorial_op_i),
    .mask_i       (simd_mask_i),
    .tag_i        (tag_i),
    .valid_o      (out_valid_o),
    .lane_valid_o (lane_valid_q),
    .fmt_o        (fmt_q),
    .vectorial_o  (vectorial_q),
    .mask_o       (mask_q),
    .tag_o        (tag_o),
    .busy_o       (busy_o)
  );

  // Output side
  simd_result_pack i_pack (
    .lane_result_i (lane_result),
    .lane_nv_i     (lane_nv),
    .lane_valid_i  (lane_valid_q),
    .mask_i        (mask_q),
    .fmt_i         (fmt_q),
    .vectorial_i   (vectorial_q),
    .result_o      (result_o),
    .status_o      (status_o)
  );

endmodule

//--- verification/noncomp_slice_properties.sv
`timescale 1ns/10ps

module noncomp_slice_props #(
  parameter int unsigned NumPipeRegs = 2
) (
  input logic                                 clk_i,
  input logic                                 rst_n_i,
  input logic                                 in_valid_i,
  input logic                                 out_valid_o,
  input logic [simd_fp_pkg::STATUS_WIDTH-1:0] status_o,
  input logic                                 busy_o
);

  // --------------------------------------------------
  // Fixed latency, in both directions
  // --------------------------------------------------
  a_valid_follows: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    in_valid_i |-> ##NumPipeRegs out_valid_o)
    else $error("out_valid_o missing NumPipeRegs cycles after in_valid_i");

  a_valid_has_source: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    out_valid_o |-> $past(in_valid_i, NumPipeRegs))
    else $error("out_valid_o without a strobe NumPipeRegs cycles earlier");

  // Status is quiet between results
  a_status_idle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !out_valid_o |-> (status_o == '0))
    else $error("status_o nonzero while out_valid_o is low");

  // Busy in every stage an operation passes, the output stage included
  for (genvar k = 1; k <= NumPipeRegs; k++) begin : gen_busy
    a_busy_in_flight: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      in_valid_i |-> ##k busy_o)
      else $error("busy_o low %0d cycles after in_valid_i", k);
  end

endmodule

bind noncomp_multifmt_slice noncomp_slice_props #(.NumPipeRegs(NumPipeRegs)) i_props (.*);

//--- verification/noncomp_slice_tb.sv
`timescale 1ns/10ps

module noncomp_slice_tb;

  localparam int unsigned NumPipeRegs = 2;
  localparam int unsigned TagWidth    = 8;
  localparam int unsigned NumTests    = 12;
  // Two clock periods per table entry plus pipeline depth and margin
  localparam int unsigned TimeoutNs   = (NumTests + NumPipeRegs + 20) * 100 * 2;

  logic                                 clk = 1'b0;
  logic                                 rst_n;
  logic                                 in_valid;
  logic [simd_fp_pkg::FLEN-1:0]         op_a;
  logic [simd_fp_pkg::FLEN-1:0]         op_b;
  simd_fp_pkg::operation_e              op;
  simd_fp_pkg::roundmode_e              rnd_mode;
  simd_fp_pkg::fp_format_e              fmt;
  logic                                 vectorial;
  logic [simd_fp_pkg::NUM_LANES-1:0]    mask;
  logic [TagWidth-1:0]                  tag;
  logic [simd_fp_pkg::FLEN-1:0]         result;
  logic [simd_fp_pkg::STATUS_WIDTH-1:0] status;
  logic [TagWidth-1:0]                  tag_out;
  logic                                 out_valid;
  logic                                 busy;

  // --------------------------------------------------
  // Stimulus table
  // --------------------------------------------------
  string                                name_t   [NumTests];
  simd_fp_pkg::operation_e              op_t     [NumTests];
  simd_fp_pkg::roundmode_e              rnd_t    [NumTests];
  simd_fp_pkg::fp_format_e              fmt_t    [NumTests];
  logic                                 vec_t    [NumTests];
  logic [simd_fp_pkg::NUM_LANES-1:0]    mask_t   [NumTests];
  logic [simd_fp_pkg::FLEN-1:0]         a_t      [NumTests];
  logic [simd_fp_pkg::FLEN-1:0]         b_t      [NumTests];
  logic [TagWidth-1:0]                  tag_t    [NumTests];
  logic [simd_fp_pkg::FLEN-1:0]         res_t    [NumTests];
  logic [simd_fp_pkg::STATUS_WIDTH-1:0] status_t [NumTests];

  int unsigned n_entries = 0;
  int unsigned n_checked = 0;
  int unsigned n_failed  = 0;
  int unsigned n_errors  = 0;

  // Cycle in which each strobe was presented
  int unsigned n_cycles  = 0;
  int unsigned n_sampled = 0;
  int unsigned issue_cycle [NumTests];

  noncomp_multifmt_slice #(.NumPipeRegs(NumPipeRegs), .TagWidth(TagWidth)) uut (
    .clk_i          (clk),
    .rst_n_i        (rst_n),
    .in_valid_i     (in_valid),
    .op_a_i         (op_a),
    .op_b_i         (op_b),
    .op_i           (op),
    .rnd_mode_i     (rnd_mode),
    .fmt_i          (fmt),
    .vectorial_op_i (vectorial),
    .simd_mask_i    (mask),
    .tag_i          (tag),
    .result_o       (result),
    .status_o       (status),
    .tag_o          (tag_out),
    .out_valid_o    (out_valid),
    .busy_o         (busy)
  );

  always #50 clk = ~clk;

  task automatic add_entry(input string name, input simd_fp_pkg::operation_e o,
                           input simd_fp_pkg::roundmode_e rm,
                           input simd_fp_pkg::fp_format_e f, input logic v,
                           input logic [3:0] m, input logic [63:0] a, input logic [63:0] b,
                           input logic [63:0] res, input logic [4:0] st);
    name_t[n_entries]   = name;
    op_t[n_entries]     = o;
    rnd_t[n_entries]    = rm;
    fmt_t[n_entries]    = f;
    vec_t[n_entries]    = v;
    mask_t[n_entries]   = m;
    a_t[n_entries]      = a;
    b_t[n_entries]      = b;
    tag_t[n_entries]    = 8'h40 + n_entries;
    res_t[n_entries]    = res;
    status_t[n_entries] = st;
    n_entries++;
  endtask

  // Expected values worked out by hand from the IEEE encodings
  task automatic fill_table();
    add_entry("fp32_min_scalar", simd_fp_pkg::MINMAX, simd_fp_pkg::RNE, simd_fp_pkg::FP32,
              1'b0, 4'b0001, 64'hFFFFFFFF_3F800000, 64'hFFFFFFFF_40000000,
              64'hFFFFFFFF_3F800000, 5'b00000);
    add_entry("fp32_max_scalar", simd_fp_pkg::MINMAX, simd_fp_pkg::RTZ, simd_fp_pkg::FP32,
              1'b0, 4'b0001, 64'hFFFFFFFF_3F800000, 64'hFFFFFFFF_40000000,
              64'hFFFFFFFF_40000000, 5'b00000);
    add_entry("fp32_min_zeros", simd_fp_pkg::MINMAX, simd_fp_pkg::RNE, simd_fp_pkg::FP32,
              1'b0, 4'b0001, 64'hFFFFFFFF_00000000, 64'hFFFFFFFF_80000000,
              64'hFFFFFFFF_80000000, 5'b00000);
    add_entry("fp32_max_zeros", simd_fp_pkg::MINMAX, simd_fp_pkg::RTZ, simd_fp_pkg::FP32,
              1'b0, 4'b0001, 64'hFFFFFFFF_00000000, 64'hFFFFFFFF_80000000,
              64'hFFFFFFFF_00000000, 5'b00000);
    add_entry("fp32_min_qnan", simd_fp_pkg::MINMAX, simd_fp_pkg::RNE, simd_fp_pkg::FP32,
              1'b0, 4'b0001, 64'hFFFFFFFF_FFC00000, 64'hFFFFFFFF_BF800000,
              64'hFFFFFFFF_BF800000, 5'b00000);
    // Lane 2 of a holds a signalling NaN
    add_entry("fp16_min_snan", simd_fp_pkg::MINMAX, simd_fp_pkg::RNE, simd_fp_pkg::FP16,
              1'b1, 4'b1111, 64'h3800_FC01_C000_3C00, 64'h0000_4200_BC00_4000,
              64'h0000_4200_C000_3C00, 5'b10000);
    add_entry("fp16_min_snan_masked", simd_fp_pkg::MINMAX, simd_fp_pkg::RNE,
              simd_fp_pkg::FP16, 1'b1, 4'b1011, 64'h3800_FC01_C000_3C00,
              64'h0000_4200_BC00_4000, 64'h0000_4200_C000_3C00, 5'b00000);
    add_entry("fp16_min_both_nan", simd_fp_pkg::MINMAX, simd_fp_pkg::RNE, simd_fp_pkg::FP16,
              1'b1, 4'b1111, 64'h3800_FC01_C000_3C00, 64'h0000_7E55_BC00_4000,
              64'h0000_7E00_C000_3C00, 5'b10000);
    add_entry("fp32_sgnj_vec", simd_fp_pkg::SGNJ, simd_fp_pkg::RNE, simd_fp_pkg::FP32,
              1'b1, 4'b0011, 64'hC0000000_3F800000, 64'hBF800000_BF800000,
              64'hC0000000_BF800000, 5'b00000);
    add_entry("fp32_sgnjn_vec", simd_fp_pkg::SGNJ, simd_fp_pkg::RTZ, simd_fp_pkg::FP32,
              1'b1, 4'b0011, 64'hC0000000_3F800000, 64'hBF800000_BF800000,
              64'h40000000_3F800000, 5'b00000);
    add_entry("fp32_sgnjx_vec", simd_fp_pkg::SGNJ, simd_fp_pkg::RDN, simd_fp_pkg::FP32,
              1'b1, 4'b0011, 64'hC0000000_3F800000, 64'hBF800000_BF800000,
              64'h40000000_BF800000, 5'b00000);
    // Operand a lacks its NaN box and reads as the canonical NaN
    add_entry("fp16_unboxed_max", simd_fp_pkg::MINMAX, simd_fp_pkg::RTZ, simd_fp_pkg::FP16,
              1'b0, 4'b0001, 64'h0000_0000_0000_3C00, 64'hFFFF_FFFF_FFFF_3800,
              64'hFFFF_FFFF_FFFF_3800, 5'b00000);
  endtask

  task automatic drive_entry(input int unsigned i);
    @(posedge clk);
    #10;
    in_valid  = 1'b1;
    op        = op_t[i];
    rnd_mode  = rnd_t[i];
    fmt       = fmt_t[i];
    vectorial = vec_t[i];
    mask      = mask_t[i];
    op_a      = a_t[i];
    op_b      = b_t[i];
    tag       = tag_t[i];
  endtask

  always @(posedge clk) begin
    if (in_valid) begin
      issue_cycle[n_sampled] = n_cycles;
      n_sampled++;
    end
    n_cycles++;
  end

  // --------------------------------------------------
  // Result checking, in issue order
  // --------------------------------------------------
  initial begin : check_results
    logic bad;
    forever begin
      @(negedge clk);
      if (busy !== (n_sampled > n_checked)) begin
        $display("busy_o is %b with %0d operations in flight", busy, n_sampled - n_checked);
        n_errors++;
      end
      if (out_valid) begin
        bad = 1'b0;
        if (n_checked >= n_entries) begin
          $display("out_valid_o was raised with no operation outstanding");
          n_errors++;
        end else begin
          if (n_cycles != issue_cycle[n_checked] + NumPipeRegs) begin
            $display("%s arrived %0d cycles after its strobe instead of %0d",
                     name_t[n_checked], n_cycles - issue_cycle[n_checked], NumPipeRegs);
            bad = 1'b1;
            n_errors++;
          end
          if (result !== res_t[n_checked]) begin
            $display("ERR %s result expected %h actual %h", name_t[n_checked],
                     res_t[n_checked], result);
            bad = 1'b1;
            n_errors++;
          end
          if (status !== status_t[n_checked]) begin
            $display("ERR %s status expected %h actual %h", name_t[n_checked],
                     status_t[n_checked], status);
            bad = 1'b1;
            n_errors++;
          end
          if (tag_out !== tag_t[n_checked]) begin
            $display("ERR %s tag expected %h actual %h", name_t[n_checked],
                     tag_t[n_checked], tag_out);
            bad = 1'b1;
            n_errors++;
          end
          if (bad) begin
            n_failed++;
          end
          $display("test %0d %s %s", n_checked, name_t[n_checked], bad ? "FAIL" : "ok");
          n_checked++;
        end
      end else if (status !== '0) begin
        $display("status_o is %h while out_valid_o is low", status);
        n_errors++;
      end
    end
  end

  initial begin : watchdog
    #(TimeoutNs);
    $display("Watchdog expired before the run completed");
    $display("Testbench failed");
    $finish;
  end

  initial begin
    rst_n     = 1'b0;
    in_valid  = 1'b0;
    op_a      = '0;
    op_b      = '0;
    op        = simd_fp_pkg::SGNJ;
    rnd_mode  = simd_fp_pkg::RNE;
    fmt       = simd_fp_pkg::FP32;
    vectorial = 1'b0;
    mask      = '0;
    tag       = '0;
    fill_table();
    repeat (16) @(posedge clk);
    #10;
    rst_n = 1'b1;
    // Back to back strobes, one per cycle
    for (int unsigned i = 0; i < n_entries; i++) begin
      drive_entry(i);
    end
    @(posedge clk);
    #10;
    in_valid = 1'b0;
    for (int w = 0; (w < NumPipeRegs + 10) && (n_checked < n_entries); w++) begin
      @(posedge clk);
    end
    // A few more cycles to catch any extra out_valid_o
    repeat (4) @(posedge clk);
    if (n_checked != n_entries) begin
      $display("Missing out_valid_o, only %0d of %0d results arrived", n_checked, n_entries);
      n_errors++;
    end
    $display("Summary: %0d checked, %0d failed, %0d errors", n_checked, n_failed, n_errors);
    if (n_errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

//--- noncomp_multifmt_slice.f
hw/simd_fp_pkg.sv
hw/simd_operand_unpack.sv
hw/noncomp_lane.sv
hw/slice_meta_pipe.sv
hw/simd_result_pack.sv
hw/noncomp_multifmt_slice.sv
verification/noncomp_slice_properties.sv
verification/noncomp_slice_tb.sv
